//--- logic/rdp_pkg.sv
package rdp_pkg;

//======================================================================
// data and address widths
//======================================================================
// one data word
localparam int DBW = 16;
// DRAM word address
localparam int GBW = 16;

//======================================================================
// chunk and slot geometry
//======================================================================
// words per DRAM beat and per read vector
localparam int CHUNK_WORDS = 4;
localparam int LANE_BW = 2;
// buffer slots, one per request in flight
localparam int N_SLOT = 4;
localparam int SLOT_BW = 2;
// max chunks in one slot / one request
localparam int SLOT_CHUNKS = 4;
// request length runs 1..SLOT_CHUNKS
localparam int LEN_BW = 3;
localparam int CIDX_BW = 2;

// slot record queue holds one record per slot and never overflows
localparam int CMDQ_DEPTH = 4;
localparam int CMDQ_BW = 2;

endpackage

//--- logic/slot_allocator.sv
`timescale 1ns/1ps

module slot_allocator import rdp_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_req_rdy,
	output logic               o_req_ack,
	input  logic [GBW-1:0]     i_req_addr,
	input  logic [LEN_BW-1:0]  i_req_len,
	output logic               o_grant_rdy,
	input  logic               i_grant_ack,
	output logic [GBW-1:0]     o_grant_addr,
	output logic [LEN_BW-1:0]  o_grant_len,
	output logic [SLOT_BW-1:0] o_grant_slot,
	input  logic               i_free_dval,
	input  logic [SLOT_BW-1:0] i_free_slot
);

logic [N_SLOT-1:0]  busy;
logic               free_any;
logic [SLOT_BW-1:0] free_id;
logic               req_fire;

// lowest free slot wins
always_comb begin
	free_id = '0;
	for (int i = N_SLOT-1; i >= 0; i--) begin
		if (!busy[i]) begin
			free_id = SLOT_BW'(i);
		end
	end
end

assign free_any = ~&busy;
assign o_req_ack = i_req_rdy && free_any && !o_grant_rdy;
assign req_fire = i_req_rdy && o_req_ack;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		busy <= '0;
		o_grant_rdy <= 1'b0;
	end else begin
		// free and take never hit the same slot
		if (i_free_dval) begin
			busy[i_free_slot] <= 1'b0;
		end
		if (req_fire) begin
			busy[free_id] <= 1'b1;
			o_grant_rdy <= 1'b1;
		end else if (i_grant_ack) begin
			o_grant_rdy <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (req_fire) begin
		o_grant_addr <= i_req_addr;
		o_grant_len <= i_req_len;
		o_grant_slot <= free_id;
	end
end

endmodule

//--- logic/chunk_addr_looper.sv
`timescale 1ns/1ps

module chunk_addr_looper import rdp_pkg::*; (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_grant_rdy,
	output logic               o_grant_ack,
	input  logic [GBW-1:0]     i_grant_addr,
	input  logic [LEN_BW-1:0]  i_grant_len,
	input  logic [SLOT_BW-1:0] i_grant_slot,
	output logic               o_dramra_rdy,
	input  logic               i_dramra_ack,
	output logic [GBW-1:0]     o_dramra,
	output logic               o_rec_rdy,
	input  logic               i_rec_ack,
	output logic [SLOT_BW-1:0] o_rec_slot,
	output logic [LEN_BW-1:0]  o_rec_len
);

//======================================================================
// address walk
//======================================================================
logic [LEN_BW-1:0]  cur_len;
logic [SLOT_BW-1:0] cur_slot;
logic [CIDX_BW-1:0] cidx;
logic               grant_fire;
logic               addr_fire;
logic               addr_last;

// slot record queue
logic [SLOT_BW-1:0] q_slot [CMDQ_DEPTH];
logic [LEN_BW-1:0]  q_len  [CMDQ_DEPTH];
logic [CMDQ_BW-1:0] q_wptr;
logic [CMDQ_BW-1:0] q_rptr;
logic [CMDQ_BW:0]   q_cnt;
logic               q_push;
logic               q_pop;

// one request at a time, and only with queue room for its record
assign o_grant_ack = i_grant_rdy && !o_dramra_rdy && (q_cnt != CMDQ_DEPTH);
assign grant_fire = i_grant_rdy && o_grant_ack;
assign addr_fire = o_dramra_rdy && i_dramra_ack;
assign addr_last = (LEN_BW'(cidx) + LEN_BW'(1)) == cur_len;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		o_dramra_rdy <= 1'b0;
		cidx <= '0;
	end else if (grant_fire) begin
		o_dramra_rdy <= 1'b1;
		cidx <= '0;
	end else if (addr_fire) begin
		cidx <= cidx + CIDX_BW'(1);
		if (addr_last) begin
			o_dramra_rdy <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (grant_fire) begin
		o_dramra <= i_grant_addr;
		cur_len <= i_grant_len;
		cur_slot <= i_grant_slot;
	end else if (addr_fire) begin
		o_dramra <= o_dramra + GBW'(CHUNK_WORDS);
	end
end

//======================================================================
// record queue
//======================================================================
// record goes out once the first address is taken
assign q_push = addr_fire && (cidx == '0);
assign q_pop = o_rec_rdy && i_rec_ack;
assign o_rec_rdy = q_cnt != '0;
assign o_rec_slot = q_slot[q_rptr];
assign o_rec_len = q_len[q_rptr];

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		q_wptr <= '0;
		q_rptr <= '0;
		q_cnt <= '0;
	end else begin
		if (q_push) begin
			q_wptr <= q_wptr + CMDQ_BW'(1);
		end
		if (q_pop) begin
			q_rptr <= q_rptr + CMDQ_BW'(1);
		end
		if (q_push && !q_pop) begin
			q_cnt <= q_cnt + 1'b1;
		end else if (q_pop && !q_push) begin
			q_cnt <= q_cnt - 1'b1;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (q_push) begin
		q_slot[q_wptr] <= cur_slot;
		q_len[q_wptr] <= cur_len;
	end
end

endmodule

//--- logic/sram_write_collector.sv
`timescale 1ns/1ps

module sram_write_collector import rdp_pkg::*; (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_rec_rdy,
	output logic                       o_rec_ack,
	input  logic [SLOT_BW-1:0]         i_rec_slot,
	input  logic [LEN_BW-1:0]          i_rec_len,
	input  logic                       i_dramrd_rdy,
	output logic                       o_dramrd_ack,
	input  logic [CHUNK_WORDS*DBW-1:0] i_dramrd,
	output logic                       o_done_rdy,
	input  logic                       i_done_ack,
	output logic [SLOT_BW-1:0]         o_done_slot,
	output logic [LEN_BW-1:0]          o_done_len,
	input  logic [SLOT_BW-1:0]         i_rd_slot,
	input  logic [CIDX_BW-1:0]         i_rd_cidx,
	output logic [CHUNK_WORDS*DBW-1:0] o_rd_bank_data
);

// one row per slot and chunk with one word per bank
logic [DBW-1:0] bank_mem [CHUNK_WORDS][N_SLOT*SLOT_CHUNKS];

logic                       rec_vld;
logic [SLOT_BW-1:0]         cur_slot;
logic [LEN_BW-1:0]          cur_len;
logic [CIDX_BW-1:0]         beat_cnt;
logic                       rec_fire;
logic                       beat_fire;
logic                       beat_last;
logic [LANE_BW-1:0]         rot;
logic [SLOT_BW+CIDX_BW-1:0] wr_row;
logic [DBW-1:0]             wr_word [CHUNK_WORDS];

// next record only after done handed off
assign o_rec_ack = i_rec_rdy && !rec_vld && !o_done_rdy;
assign rec_fire = i_rec_rdy && o_rec_ack;
assign o_dramrd_ack = rec_vld;
assign beat_fire = i_dramrd_rdy && o_dramrd_ack;
assign beat_last = (LEN_BW'(beat_cnt) + LEN_BW'(1)) == cur_len;

// record stays put until done is acked
assign o_done_slot = cur_slot;
assign o_done_len = cur_len;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		rec_vld <= 1'b0;
		o_done_rdy <= 1'b0;
		beat_cnt <= '0;
	end else begin
		if (rec_fire) begin
			rec_vld <= 1'b1;
			beat_cnt <= '0;
		end else if (beat_fire) begin
			beat_cnt <= beat_cnt + CIDX_BW'(1);
			if (beat_last) begin
				rec_vld <= 1'b0;
				o_done_rdy <= 1'b1;
			end
		end
		if (o_done_rdy && i_done_ack) begin
			o_done_rdy <= 1'b0;
		end
	end
end

always_ff @(posedge i_clk) begin
	if (rec_fire) begin
		cur_slot <= i_rec_slot;
		cur_len <= i_rec_len;
	end
end

//======================================================================
// banked buffer, XOR rotated by chunk index
//======================================================================
assign rot = LANE_BW'(beat_cnt);
assign wr_row = {cur_slot, beat_cnt};

// bank b takes word b ^ rot so word j lands in bank j ^ rot
always_comb begin
	for (int b = 0; b < CHUNK_WORDS; b++) begin
		wr_word[b] = i_dramrd[DBW*(LANE_BW'(b) ^ rot) +: DBW];
	end
end

always_ff @(posedge i_clk) begin
	if (beat_fire) begin
		for (int b = 0; b < CHUNK_WORDS; b++) begin
			bank_mem[b][wr_row] <= wr_word[b];
		end
	end
end

// async read of a whole row for the reader
always_comb begin
	for (int b = 0; b < CHUNK_WORDS; b++) begin
		o_rd_bank_data[DBW*b +: DBW] = bank_mem[b][{i_rd_slot, i_rd_cidx}];
	end
end

endmodule

//--- logic/remap_reader.sv
`timescale 1ns/1ps

module remap_reader import rdp_pkg::*; (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_done_rdy,
	output logic                       o_done_ack,
	input  logic [SLOT_BW-1:0]         i_done_slot,
	input  logic [LEN_BW-1:0]          i_done_len,
	output logic [SLOT_BW-1:0]         o_rd_slot,
	output logic [CIDX_BW-1:0]         o_rd_cidx,
	input  logic [CHUNK_WORDS*DBW-1:0] i_rd_bank_data,
	output logic                       o_sramrd_rdy,
	input  logic                       i_sramrd_ack,
	output logic [CHUNK_WORDS*DBW-1:0] o_sramrd,
	output logic                       o_sramrd_last,
	output logic                       o_free_dval,
	output logic [SLOT_BW-1:0]         o_free_slot
);

logic [SLOT_BW-1:0]         cur_slot;
logic [LEN_BW-1:0]          cur_len;
logic [CIDX_BW-1:0]         cidx;
logic                       done_fire;
logic                       vec_fire;
logic [LANE_BW-1:0]         rot;
logic [CHUNK_WORDS*DBW-1:0] load_vec;

// o_sramrd_rdy doubles as the busy flag of the reader
assign o_done_ack = i_done_rdy && !o_sramrd_rdy;
assign done_fire = i_done_rdy && o_done_ack;
assign vec_fire = o_sramrd_rdy && i_sramrd_ack;

// fetch chunk 0 of a new slot or the chunk after the current one
assign o_rd_slot = o_sramrd_rdy ? cur_slot : i_done_slot;
assign o_rd_cidx = o_sramrd_rdy ? cidx + CIDX_BW'(1) : '0;

// undo the write-side rotation
assign rot = LANE_BW'(o_rd_cidx);
always_comb begin
	for (int j = 0; j < CHUNK_WORDS; j++) begin
		load_vec[DBW*j +: DBW] = i_rd_bank_data[DBW*(LANE_BW'(j) ^ rot) +: DBW];
	end
end

// cur_slot holds through the free pulse cycle
assign o_free_slot = cur_slot;

always_ff @(posedge i_clk or negedge i_rst) begin
	if (!i_rst) begin
		o_sramrd_rdy <= 1'b0;
		o_free_dval <= 1'b0;
		cidx <= '0;
	end else begin
		o_free_dval <= 1'b0;
		if (done_fire) begin
			o_sramrd_rdy <= 1'b1;
			cidx <= '0;
		end else if (vec_fire) begin
			if (o_sramrd_last) begin
				o_sramrd_rdy <= 1'b0;
				o_free_dval <= 1'b1;
			end else begin
				cidx <= cidx + CIDX_BW'(1);
			end
		end
	end
end

always_ff @(posedge i_clk) begin
	if (done_fire) begin
		cur_slot <= i_done_slot;
		cur_len <= i_done_len;
		o_sramrd <= load_vec;
		o_sramrd_last <= i_done_len == LEN_BW'(1);
	end else if (vec_fire && !o_sramrd_last) begin
		o_sramrd <= load_vec;
		// next vector is cidx+1 and is last when cidx+2 reaches the length
		o_sramrd_last <= (LEN_BW'(cidx) + LEN_BW'(2)) == cur_len;
	end
end

endmodule

//--- logic/read_pipeline.sv
`timescale 1ns/1ps

module read_pipeline import rdp_pkg::*; (
	input  logic                       i_clk,
	input  logic                       i_rst,
	input  logic                       i_req_rdy,
	output logic                       o_req_ack,
	input  logic [GBW-1:0]             i_req_addr,
	input  logic [LEN_BW-1:0]          i_req_len,
	output logic                       o_dramra_rdy,
	input  logic                       i_dramra_ack,
	output logic [GBW-1:0]             o_dramra,
	input  logic                       i_dramrd_rdy,
	output logic                       o_dramrd_ack,
	input  logic [CHUNK_WORDS*DBW-1:0] i_dramrd,
	output logic                       o_sramrd_rdy,
	input  logic                       i_sramrd_ack,
	output logic [CHUNK_WORDS*DBW-1:0] o_sramrd,
	output logic                       o_sramrd_last
);

//======================================================================
// internal links
//======================================================================
// allocator -> looper
logic                       grant_rdy;
logic                       grant_ack;
logic [GBW-1:0]             grant_addr;
logic [LEN_BW-1:0]          grant_len;
logic [SLOT_BW-1:0]         grant_slot;
// looper -> collector
logic                       rec_rdy;
logic                       rec_ack;
logic [SLOT_BW-1:0]         rec_slot;
logic [LEN_BW-1:0]          rec_len;
// collector -> reader
logic                       done_rdy;
logic                       done_ack;
logic [SLOT_BW-1:0]         done_slot;
logic [LEN_BW-1:0]          done_len;
// buffer read port
logic [SLOT_BW-1:0]         rd_slot;
logic [CIDX_BW-1:0]         rd_cidx;
logic [CHUNK_WORDS*DBW-1:0] rd_bank_data;
// reader -> allocator
logic                       free_dval;
logic [SLOT_BW-1:0]         free_slot;

//======================================================================
// stages
//======================================================================
slot_allocator slot_allocator_i (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_req_rdy    (i_req_rdy),
	.o_req_ack    (o_req_ack),
	.i_req_addr   (i_req_addr),
	.i_req_len    (i_req_len),
	.o_grant_rdy  (grant_rdy),
	.i_grant_ack  (grant_ack),
	.o_grant_addr (grant_addr),
	.o_grant_len  (grant_len),
	.o_grant_slot (grant_slot),
	.i_free_dval  (free_dval),
	.i_free_slot  (free_slot)
);

chunk_addr_looper chunk_addr_looper_i (
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_grant_rdy  (grant_rdy),
	.o_grant_ack  (grant_ack),
	.i_grant_addr (grant_addr),
	.i_grant_len  (grant_len),
	.i_grant_slot (grant_slot),
	.o_dramra_rdy (o_dramra_rdy),
	.i_dramra_ack (i_dramra_ack),
	.o_dramra     (o_dramra),
	.o_rec_rdy    (rec_rdy),
	.i_rec_ack    (rec_ack),
	.o_rec_slot   (rec_slot),
	.o_rec_len    (rec_len)
);

sram_write_collector sram_write_collector_i (
	.i_clk          (i_clk),
	.i_rst          (i_rst),
	.i_rec_rdy      (rec_rdy),
	.o_rec_ack      (rec_ack),
	.i_rec_slot     (rec_slot),
	.i_rec_len      (rec_len),
	.i_dramrd_rdy   (i_dramrd_rdy),
	.o_dramrd_ack   (o_dramrd_ack),
	.i_dramrd       (i_dramrd),
	.o_done_rdy     (done_rdy),
	.i_done_ack     (done_ack),
	.o_done_slot    (done_slot),
	.o_done_len     (done_len),
	.i_rd_slot      (rd_slot),
	.i_rd_cidx      (rd_cidx),
	.o_rd_bank_data (rd_bank_data)
);

remap_reader remap_reader_i (
	.i_clk          (i_clk),
	.i_rst          (i_rst),
	.i_done_rdy     (done_rdy),
	.o_done_ack     (done_ack),
	.i_done_slot    (done_slot),
	.i_done_len     (done_len),
	.o_rd_slot      (rd_slot),
	.o_rd_cidx      (rd_cidx),
	.i_rd_bank_data (rd_bank_data),
	.o_sramrd_rdy   (o_sramrd_rdy),
	.i_sramrd_ack   (i_sramrd_ack),
	.o_sramrd       (o_sramrd),
	.o_sramrd_last  (o_sramrd_last),
	.o_free_dval    (free_dval),
	.o_free_slot    (free_slot)
);

endmodule

//--- tb/rdp_checks.svh
`ifndef RDP_CHECKS_SVH
`define RDP_CHECKS_SVH

//======================================================================
// one error counter per kind of check
//======================================================================
int err_word = 0;
int err_addr = 0;
int err_flag = 0;
int err_other = 0;

// one result word
task automatic check_word(input string name, input logic [DBW-1:0] exp,
		input logic [DBW-1:0] act);
	if (act !== exp) begin
		err_word++;
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
	end
endtask

// one DRAM word address
task automatic check_addr(input string name, input logic [GBW-1:0] exp,
		input logic [GBW-1:0] act);
	if (act !== exp) begin
		err_addr++;
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
	end
endtask

// last flag and idle handshake bits
task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		err_flag++;
		$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
	end
endtask

// anything that is not a wrong value
task automatic note_failure(input string msg);
	err_other++;
	$display("%s", msg);
endtask

`endif

//--- tb/tb_read_pipeline.sv
`timescale 1ns/1ps

module tb_read_pipeline import rdp_pkg::*; ();

localparam int N_REQ = 200;
localparam int SLOW_FROM = 100;
localparam int TMO = 3000;
localparam int STALL_MIN = 10;

logic                       i_clk;
logic                       i_rst;
logic                       i_req_rdy;
logic                       o_req_ack;
logic [GBW-1:0]             i_req_addr;
logic [LEN_BW-1:0]          i_req_len;
logic                       o_dramra_rdy;
logic                       i_dramra_ack;
logic [GBW-1:0]             o_dramra;
logic                       i_dramrd_rdy;
logic                       o_dramrd_ack;
logic [CHUNK_WORDS*DBW-1:0] i_dramrd;
logic                       o_sramrd_rdy;
logic                       i_sramrd_ack;
logic [CHUNK_WORDS*DBW-1:0] o_sramrd;
logic                       o_sramrd_last;

// expected DRAM addresses, vector base word addresses and last flags
logic [GBW-1:0] exp_addr_q [$];
logic [GBW-1:0] exp_vec_q [$];
logic           exp_last_q [$];
// accepted DRAM addresses waiting for their beat
logic [GBW-1:0] dram_q [$];

logic           ra_taken = 1'b0;
logic [GBW-1:0] ra_taken_addr = '0;
logic           rd_taken = 1'b0;
int             ack_pct = 70;
int             slow_stalls = 0;
logic           in_slow = 1'b0;
logic           timed_out = 1'b0;

`include "rdp_checks.svh"

read_pipeline read_pipeline_i (
	.i_clk         (i_clk),
	.i_rst         (i_rst),
	.i_req_rdy     (i_req_rdy),
	.o_req_ack     (o_req_ack),
	.i_req_addr    (i_req_addr),
	.i_req_len     (i_req_len),
	.o_dramra_rdy  (o_dramra_rdy),
	.i_dramra_ack  (i_dramra_ack),
	.o_dramra      (o_dramra),
	.i_dramrd_rdy  (i_dramrd_rdy),
	.o_dramrd_ack  (o_dramrd_ack),
	.i_dramrd      (i_dramrd),
	.o_sramrd_rdy  (o_sramrd_rdy),
	.i_sramrd_ack  (i_sramrd_ack),
	.o_sramrd      (o_sramrd),
	.o_sramrd_last (o_sramrd_last)
);

initial begin
	i_clk = 1'b0;
	forever #10 i_clk = ~i_clk;
end

// fixed DRAM data pattern per word address
function automatic logic [DBW-1:0] word_hash(input logic [GBW-1:0] a);
	return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h5a3c;
endfunction

function automatic logic [CHUNK_WORDS*DBW-1:0] beat_data(input logic [GBW-1:0] a);
	logic [CHUNK_WORDS*DBW-1:0] d;
	for (int j = 0; j < CHUNK_WORDS; j++) begin
		d[DBW*j +: DBW] = word_hash(a + GBW'(j));
	end
	return d;
endfunction

//======================================================================
// DRAM responder and result sink, driven on the rising edge
//======================================================================
always @(posedge i_clk) begin
	i_dramra_ack <= ($urandom % 4) != 0;
	// a beat holds until taken and is followed by a random gap
	if (!i_dramrd_rdy || rd_taken) begin
		if (dram_q.size() > 0 && ($urandom % 3) != 0) begin
			i_dramrd <= beat_data(dram_q.pop_front());
			i_dramrd_rdy <= 1'b1;
		end else begin
			i_dramrd_rdy <= 1'b0;
		end
	end
	// queued after the beat choice, so a beat never precedes its address
	if (ra_taken) begin
		dram_q.push_back(ra_taken_addr);
	end
	i_sramrd_ack <= ($urandom % 100) < ack_pct;
end

// each flag sampled mid-cycle means a transfer on the next rising edge
always @(negedge i_clk) begin
	logic [GBW-1:0] base;
	logic           last;
	ra_taken = o_dramra_rdy && i_dramra_ack;
	ra_taken_addr = o_dramra;
	rd_taken = i_dramrd_rdy && o_dramrd_ack;
	if (ra_taken) begin
		if (exp_addr_q.size() == 0) begin
			note_failure("a DRAM address was issued with no request pending");
		end else begin
			check_addr("dram address", exp_addr_q.pop_front(), o_dramra);
		end
	end
	if (o_sramrd_rdy && i_sramrd_ack) begin
		if (exp_vec_q.size() == 0) begin
			note_failure("a result vector came out with no request pending");
		end else begin
			base = exp_vec_q.pop_front();
			last = exp_last_q.pop_front();
			for (int j = 0; j < CHUNK_WORDS; j++) begin
				check_word("result word", word_hash(base + GBW'(j)), o_sramrd[DBW*j +: DBW]);
			end
			check_bit("last flag", last, o_sramrd_last);
		end
	end
end

//======================================================================
// requests
//======================================================================
task automatic send_request(input int n);
	logic [GBW-1:0]    addr;
	logic [LEN_BW-1:0] len;
	int                wait_cyc;
	logic              taken;
	addr = GBW'($urandom);
	len = LEN_BW'(1 + $urandom % SLOT_CHUNKS);
	wait_cyc = 0;
	taken = 1'b0;
	@(posedge i_clk);
	i_req_rdy <= 1'b1;
	i_req_addr <= addr;
	i_req_len <= len;
	while (!taken && !timed_out) begin
		@(negedge i_clk);
		if (o_req_ack) begin
			taken = 1'b1;
		end else if (wait_cyc == TMO) begin
			$display("request %0d was not accepted within %0d cycles", n, TMO);
			err_other++;
			timed_out = 1'b1;
		end else begin
			wait_cyc++;
		end
	end
	if (taken) begin
		for (int k = 0; k < int'(len); k++) begin
			exp_addr_q.push_back(addr + GBW'(k * CHUNK_WORDS));
			exp_vec_q.push_back(addr + GBW'(k * CHUNK_WORDS));
			exp_last_q.push_back(k == int'(len) - 1);
		end
		// a long wait that ended in a transfer is a stall that resumed
		if (in_slow && wait_cyc >= STALL_MIN) begin
			slow_stalls++;
		end
		@(posedge i_clk);
		i_req_rdy <= 1'b0;
		repeat ($urandom % 3) @(posedge i_clk);
	end
endtask

task automatic wait_drain();
	int wait_cyc;
	wait_cyc = 0;
	while ((exp_vec_q.size() != 0 || exp_addr_q.size() != 0) && !timed_out) begin
		@(posedge i_clk);
		if (wait_cyc == TMO) begin
			$display("pipeline did not drain within %0d cycles, %0d vectors missing",
				TMO, exp_vec_q.size());
			err_other++;
			timed_out = 1'b1;
		end else begin
			wait_cyc++;
		end
	end
endtask

initial begin
	void'($urandom(32'h1828));
	i_rst = 1'b0;
	i_req_rdy = 1'b0;
	i_req_addr = '0;
	i_req_len = '0;
	i_dramra_ack = 1'b0;
	i_dramrd_rdy = 1'b0;
	i_dramrd = '0;
	i_sramrd_ack = 1'b0;
	repeat (10) @(posedge i_clk);
	i_rst <= 1'b1;
	// idle outputs before the first request
	@(negedge i_clk);
	check_bit("req ack after reset", 1'b0, o_req_ack);
	check_bit("dram addr rdy after reset", 1'b0, o_dramra_rdy);
	check_bit("dram data ack after reset", 1'b0, o_dramrd_ack);
	check_bit("result rdy after reset", 1'b0, o_sramrd_rdy);
	for (int n = 0; n < N_REQ && !timed_out; n++) begin
		// second half runs against a slow sink
		if (n == SLOW_FROM) begin
			@(negedge i_clk);
			ack_pct = 20;
			in_slow = 1'b1;
		end
		send_request(n);
	end
	wait_drain();
	repeat (20) @(posedge i_clk);
	@(negedge i_clk);
	if (!timed_out) begin
		check_bit("result rdy when drained", 1'b0, o_sramrd_rdy);
		if (dram_q.size() != 0) begin
			note_failure("DRAM beats were left over after the last result");
		end
		if (slow_stalls == 0) begin
			note_failure("the request port never stalled and resumed under the slow sink");
		end
	end
	$display("errors: word %0d, address %0d, flag %0d, other %0d",
		err_word, err_addr, err_flag, err_other);
	if (err_word + err_addr + err_flag + err_other == 0) begin
		$display("TESTBENCH PASSED");
	end else begin
		$display("TESTBENCH FAILED");
	end
	$finish;
end

endmodule

//--- verilog.f
+incdir+tb
logic/rdp_pkg.sv
logic/slot_allocator.sv
logic/chunk_addr_looper.sv
logic/sram_write_collector.sv
logic/remap_reader.sv
logic/read_pipeline.sv
tb/tb_read_pipeline.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_read_pipeline -f verilog.f \
	-o tb_read_pipeline > build.log 2>&1 \
	&& ./obj_dir/tb_read_pipeline > sim.log 2>&1 \
	|| { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
